// ==== list.f ====
+incdir+hdl
hdl/rv_pkg.sv
hdl/mem_stage.sv
hdl/memwb_register.sv
hdl/writeback_stage.sv
hdl/regfile.sv
hdl/memwb_top.sv
test/memwb_chk.sv
test/memwb_monitor.sv
test/memwb_tb.sv

// ==== Makefile ====
# Verilator flow for the MEM/WB back end

VERILATOR ?= verilator
TOP       ?= memwb_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Simulation failed
PASS_MSG  ?= Simulation completed successfully
VFLAGS    ?= --binary --timing --assert -j 0 -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

sim: build
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Run reported failure, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Run ended early, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== test/memwb_tb.sv ====
// ====================
// Testbench for memwb_top. Expects XLEN 32
// Table entries go in back to back, then both files are read back
// ====================

`timescale 1ns/1ps
`default_nettype none

`include "rv_consts.svh"

bind memwb_top memwb_chk chk_i (
  .clk       (clk),
  .reset_n   (reset_n),
  .int_we    (int_we),
  .int_waddr (int_waddr),
  .fp_we     (fp_we),
  .fflags    (fflags)
);

module memwb_tb;

  typedef struct packed {
    logic                   int_we;
    logic [`REG_ADDR_W-1:0] int_waddr;
    logic [`XLEN-1:0]       int_wdata;
    logic                   fp_we;
    logic [`REG_ADDR_W-1:0] fp_waddr;
    logic [`XLEN-1:0]       fp_wdata;
    logic [4:0]             fflags;
  } expect_t;

  logic                   clk;
  logic                   reset_n;
  rv_pkg::ex_mem_t        ex_mem;
  logic [`XLEN-1:0]       dmem_rdata;
  logic                   int_we;
  logic [`REG_ADDR_W-1:0] int_waddr;
  logic [`XLEN-1:0]       int_wdata;
  logic                   fp_we;
  logic [`REG_ADDR_W-1:0] fp_waddr;
  logic [`XLEN-1:0]       fp_wdata;
  rv_pkg::fp_flags_t      fflags;
  logic [`REG_ADDR_W-1:0] int_raddr;
  logic [`XLEN-1:0]       int_rdata;
  logic [`REG_ADDR_W-1:0] fp_raddr;
  logic [`XLEN-1:0]       fp_rdata;

  // Test table, one entry per test
  string            names[$];
  rv_pkg::ex_mem_t  stims[$];
  logic [`XLEN-1:0] words[$];
  expect_t          expects[$];

  // Reference register state and flags, built up with the table
  logic [`XLEN-1:0] int_shadow [`NUM_REGS];
  logic [`XLEN-1:0] fp_shadow [`NUM_REGS];
  logic [4:0]       flag_acc;
  logic [31:0]      rng_state;
  bit               table_ready;

  memwb_top dut_i (
    .clk (clk), .reset_n (reset_n), .ex_mem (ex_mem), .dmem_rdata (dmem_rdata),
    .int_we (int_we), .int_waddr (int_waddr), .int_wdata (int_wdata),
    .fp_we (fp_we), .fp_waddr (fp_waddr), .fp_wdata (fp_wdata), .fflags (fflags),
    .int_raddr (int_raddr), .int_rdata (int_rdata),
    .fp_raddr (fp_raddr), .fp_rdata (fp_rdata)
  );

  memwb_monitor mon_i (
    .clk (clk), .int_we (int_we), .int_waddr (int_waddr), .int_wdata (int_wdata),
    .fp_we (fp_we), .fp_waddr (fp_waddr), .fp_wdata (fp_wdata), .fflags (fflags),
    .int_rdata (int_rdata), .fp_rdata (fp_rdata)
  );

  function automatic logic [31:0] xorshift32();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // Load result from the RISC-V rules for each opcode
  function automatic logic [31:0] load_value(input rv_pkg::mem_op_e op,
                                             input logic [31:0] addr, input logic [31:0] word);
    logic [7:0]  b;
    logic [15:0] h;
    b = word[8*addr[1:0] +: 8];
    h = addr[1] ? word[31:16] : word[15:0];
    case (op)
      rv_pkg::MEM_LB:  return {{24{b[7]}}, b};
      rv_pkg::MEM_LBU: return {24'h0, b};
      rv_pkg::MEM_LH:  return {{16{h[15]}}, h};
      rv_pkg::MEM_LHU: return {16'h0, h};
      rv_pkg::MEM_LW:  return word;
      default:         return 32'h0;
    endcase
  endfunction

  // Valid item with random data in every source and no write flags
  function automatic rv_pkg::ex_mem_t base_item();
    rv_pkg::ex_mem_t s;
    logic [31:0]     r;
    s = '0;
    r = xorshift32();
    s.valid          = 1'b1;
    s.fp_flags       = r[4:0];
    s.fp_rd_addr     = r[12:8];
    s.alu_result     = xorshift32();
    s.pc_plus_4      = xorshift32();
    s.mul_div_result = xorshift32();
    s.atomic_result  = xorshift32();
    s.csr_rdata      = xorshift32();
    s.fp_result      = xorshift32();
    s.int_result_fp  = xorshift32();
    return s;
  endfunction

  function automatic rv_pkg::ex_mem_t sel_item(input rv_pkg::wb_sel_e sel, input int rd);
    rv_pkg::ex_mem_t s;
    s = base_item();
    s.reg_write = 1'b1;
    s.wb_sel    = sel;
    s.rd_addr   = 5'(rd);
    return s;
  endfunction

  function automatic rv_pkg::ex_mem_t load_item(input rv_pkg::mem_op_e op, input int off,
                                                input int rd);
    rv_pkg::ex_mem_t s;
    s = sel_item(rv_pkg::WB_MEM, rd);
    s.mem_op          = op;
    s.alu_result[1:0] = 2'(off);
    return s;
  endfunction

  function automatic rv_pkg::ex_mem_t fp_item(input int fd, input logic [4:0] flags);
    rv_pkg::ex_mem_t s;
    s = base_item();
    s.fp_reg_write = 1'b1;
    s.fp_rd_addr   = 5'(fd);
    s.fp_flags     = flags;
    return s;
  endfunction

  task automatic add_test(input string name, input rv_pkg::ex_mem_t s, input logic [31:0] word);
    expect_t     e;
    logic [31:0] sel;
    case (s.wb_sel)
      rv_pkg::WB_MEM:    sel = load_value(s.mem_op, s.alu_result, word);
      rv_pkg::WB_PC4:    sel = s.pc_plus_4;
      rv_pkg::WB_MULDIV: sel = s.mul_div_result;
      rv_pkg::WB_ATOMIC: sel = s.atomic_result;
      rv_pkg::WB_CSR:    sel = s.csr_rdata;
      default:           sel = s.alu_result;
    endcase
    e.int_we    = s.valid && (s.reg_write || s.int_reg_write_fp) && (s.rd_addr != '0);
    e.int_waddr = s.rd_addr;
    e.int_wdata = s.int_reg_write_fp ? s.int_result_fp : sel;
    e.fp_we     = s.valid && s.fp_reg_write;
    e.fp_waddr  = s.fp_rd_addr;
    e.fp_wdata  = s.fp_result;
    if (s.valid && (s.fp_reg_write || s.int_reg_write_fp)) begin
      flag_acc = flag_acc | s.fp_flags;
    end
    e.fflags = flag_acc;
    if (e.int_we) begin
      int_shadow[s.rd_addr] = e.int_wdata;
    end
    if (e.fp_we) begin
      fp_shadow[s.fp_rd_addr] = e.fp_wdata;
    end
    names.push_back(name);
    stims.push_back(s);
    words.push_back(word);
    expects.push_back(e);
  endtask

  task automatic build_table();
    rv_pkg::ex_mem_t s;
    logic [31:0]     word;
    // Sign bit set in every byte lane
    word = xorshift32() | 32'h8080_8080;
    for (int off = 0; off < 4; off++) begin
      add_test($sformatf("lb_off%0d", off), load_item(rv_pkg::MEM_LB, off, 1 + off), word);
      add_test($sformatf("lbu_off%0d", off), load_item(rv_pkg::MEM_LBU, off, 5 + off), word);
    end
    for (int off = 0; off < 4; off += 2) begin
      add_test($sformatf("lh_off%0d", off), load_item(rv_pkg::MEM_LH, off, 9 + off / 2), word);
      add_test($sformatf("lhu_off%0d", off), load_item(rv_pkg::MEM_LHU, off, 11 + off / 2), word);
    end
    add_test("lw_off0", load_item(rv_pkg::MEM_LW, 0, 13), word);
    add_test("sel_alu", sel_item(rv_pkg::WB_ALU, 14), xorshift32());
    add_test("sel_pc4", sel_item(rv_pkg::WB_PC4, 15), xorshift32());
    add_test("sel_muldiv", sel_item(rv_pkg::WB_MULDIV, 16), xorshift32());
    add_test("sel_atomic", sel_item(rv_pkg::WB_ATOMIC, 17), xorshift32());
    add_test("sel_csr", sel_item(rv_pkg::WB_CSR, 18), xorshift32());
    s = sel_item(rv_pkg::WB_CSR, 19);
    s.reg_write        = 1'b0;
    s.int_reg_write_fp = 1'b1;
    s.fp_flags         = 5'b10000;
    add_test("fp_to_int_override", s, xorshift32());
    add_test("x0_write", sel_item(rv_pkg::WB_ALU, 0), xorshift32());
    s = sel_item(rv_pkg::WB_ALU, 20);
    s.valid        = 1'b0;
    s.fp_reg_write = 1'b1;
    s.fp_flags     = 5'b11111;
    add_test("valid_low", s, xorshift32());
    s = sel_item(rv_pkg::WB_ALU, 21);
    s.reg_write = 1'b0;
    s.fp_flags  = 5'b11111;
    add_test("no_reg_write", s, xorshift32());
    add_test("fp_write_f3", fp_item(3, 5'b00001), xorshift32());
    add_test("fp_write_f0", fp_item(0, 5'b00100), xorshift32());
    add_test("fp_flags_dz", fp_item(7, 5'b01000), xorshift32());
    add_test("b2b_x14", sel_item(rv_pkg::WB_ALU, 14), xorshift32());
    add_test("b2b_x14_again", sel_item(rv_pkg::WB_MULDIV, 14), xorshift32());
    add_test("b2b_f3", fp_item(3, 5'b00010), xorshift32());
  endtask

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Limit covers the table, the read-back sweep, reset and drain
  initial begin
    int limit_ns;
    wait (table_ready);
    limit_ns = (names.size() + `NUM_REGS + 10) * 40;
    #(limit_ns);
    $display("Timeout: run did not finish within %0d ns", limit_ns);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    reset_n     = 1'b0;
    // Item that would write both files and raise every flag, held through reset
    ex_mem              = '0;
    ex_mem.valid        = 1'b1;
    ex_mem.reg_write    = 1'b1;
    ex_mem.rd_addr      = 5'd1;
    ex_mem.alu_result   = 32'h5a5a_a5a5;
    ex_mem.fp_reg_write = 1'b1;
    ex_mem.fp_result    = 32'ha5a5_5a5a;
    ex_mem.fp_flags     = 5'b11111;
    dmem_rdata  = '0;
    int_raddr   = '0;
    fp_raddr    = '0;
    rng_state   = 32'h51cfa0b0;
    flag_acc    = '0;
    table_ready = 1'b0;
    for (int r = 0; r < `NUM_REGS; r++) begin
      int_shadow[r] = '0;
      fp_shadow[r]  = '0;
    end
    build_table();
    table_ready = 1'b1;
    repeat (2) @(posedge clk);
    @(negedge clk);
    ex_mem  = '0;
    reset_n = 1'b1;
    for (int i = 0; i < names.size(); i++) begin
      @(negedge clk);
      ex_mem     = stims[i];
      dmem_rdata = words[i];
      mon_i.expect_item(names[i], expects[i].int_we, expects[i].int_waddr,
                        expects[i].int_wdata, expects[i].fp_we, expects[i].fp_waddr,
                        expects[i].fp_wdata, expects[i].fflags);
    end
    @(negedge clk);
    ex_mem = '0;
    wait (mon_i.done_count == names.size());
    for (int r = 0; r < `NUM_REGS; r++) begin
      @(negedge clk);
      int_raddr = 5'(r);
      fp_raddr  = 5'(r);
      @(posedge clk);
      mon_i.check_read(r, int_shadow[r], fp_shadow[r]);
    end
    mon_i.end_test("readback");
    mon_i.report(dut_i.chk_i.fail_count);
    if (mon_i.fail_count == 0 && dut_i.chk_i.fail_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== test/memwb_monitor.sv ====
// ====================
// Write ports are checked one cycle after each item, fflags on the
// following falling edge once the flag register has updated
// ====================

`timescale 1ns/1ps
`default_nettype none

`include "rv_consts.svh"

module memwb_monitor (
  input logic                   clk,
  input logic                   int_we,
  input logic [`REG_ADDR_W-1:0] int_waddr,
  input logic [`XLEN-1:0]       int_wdata,
  input logic                   fp_we,
  input logic [`REG_ADDR_W-1:0] fp_waddr,
  input logic [`XLEN-1:0]       fp_wdata,
  input logic [4:0]             fflags,
  input logic [`XLEN-1:0]       int_rdata,
  input logic [`XLEN-1:0]       fp_rdata
);

  typedef struct packed {
    logic                   int_we;
    logic [`REG_ADDR_W-1:0] int_waddr;
    logic [`XLEN-1:0]       int_wdata;
    logic                   fp_we;
    logic [`REG_ADDR_W-1:0] fp_waddr;
    logic [`XLEN-1:0]       fp_wdata;
    logic [4:0]             fflags;
  } item_t;

  item_t item_q[$];
  string name_q[$];
  item_t port_item;
  item_t flag_item;
  string port_name;
  string flag_name;
  bit    port_busy = 1'b0;
  bit    flag_busy = 1'b0;
  int    test_errs = 0;
  int    pass_count = 0;
  int    fail_count = 0;
  int    done_count = 0;

  task automatic expect_item(
    input string                  name,
    input logic                   e_int_we,
    input logic [`REG_ADDR_W-1:0] e_int_waddr,
    input logic [`XLEN-1:0]       e_int_wdata,
    input logic                   e_fp_we,
    input logic [`REG_ADDR_W-1:0] e_fp_waddr,
    input logic [`XLEN-1:0]       e_fp_wdata,
    input logic [4:0]             e_fflags
  );
    item_t it;
    it = {e_int_we, e_int_waddr, e_int_wdata, e_fp_we, e_fp_waddr, e_fp_wdata, e_fflags};
    item_q.push_back(it);
    name_q.push_back(name);
  endtask

  task automatic compare(input string what, input logic [`XLEN-1:0] exp,
                         input logic [`XLEN-1:0] act);
    if (exp !== act) begin
      $display("Error %s expected 0x%h actual 0x%h", what, exp, act);
      test_errs++;
    end
  endtask

  task automatic end_test(input string name);
    if (test_errs == 0) begin
      $display("PASS %s", name);
      pass_count++;
    end else begin
      $display("FAIL %s with %0d mismatches", name, test_errs);
      fail_count++;
    end
    test_errs = 0;
    done_count++;
  endtask

  task automatic check_read(input int r, input logic [`XLEN-1:0] exp_int,
                            input logic [`XLEN-1:0] exp_fp);
    compare($sformatf("readback x%0d", r), exp_int, int_rdata);
    compare($sformatf("readback f%0d", r), exp_fp, fp_rdata);
  endtask

  task automatic report(input int assert_fails);
    $display("Summary: %0d passed, %0d failed, %0d assertion failures",
             pass_count, fail_count, assert_fails);
  endtask

  // Item popped at edge k is on the write ports until edge k+1
  always @(posedge clk) begin
    if (port_busy) begin
      compare({port_name, " int_we"}, `XLEN'(port_item.int_we), `XLEN'(int_we));
      if (port_item.int_we) begin
        compare({port_name, " int_waddr"}, `XLEN'(port_item.int_waddr), `XLEN'(int_waddr));
        compare({port_name, " int_wdata"}, port_item.int_wdata, int_wdata);
      end
      compare({port_name, " fp_we"}, `XLEN'(port_item.fp_we), `XLEN'(fp_we));
      if (port_item.fp_we) begin
        compare({port_name, " fp_waddr"}, `XLEN'(port_item.fp_waddr), `XLEN'(fp_waddr));
        compare({port_name, " fp_wdata"}, port_item.fp_wdata, fp_wdata);
      end
      flag_item = port_item;
      flag_name = port_name;
      flag_busy = 1'b1;
    end
    port_busy = (item_q.size() > 0);
    if (port_busy) begin
      port_item = item_q.pop_front();
      port_name = name_q.pop_front();
    end
  end

  always @(negedge clk) begin
    if (flag_busy) begin
      compare({flag_name, " fflags"}, `XLEN'(flag_item.fflags), `XLEN'(fflags));
      end_test(flag_name);
      flag_busy = 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== test/memwb_chk.sv ====
// ====================
// Assertions bound into memwb_top
// All checks sample on the rising clock edge
// ====================

`timescale 1ns/1ps
`default_nettype none

`include "rv_consts.svh"

module memwb_chk (
  input logic                   clk,
  input logic                   reset_n,
  input logic                   int_we,
  input logic [`REG_ADDR_W-1:0] int_waddr,
  input logic                   fp_we,
  input logic [4:0]             fflags
);

  int fail_count = 0;

  // Register is held clear in reset, so neither file may be written
  no_write_in_reset: assert property (@(posedge clk) !reset_n |-> (!int_we && !fp_we))
    else begin
      $error("write enable active during reset");
      fail_count++;
    end

  no_x0_write: assert property (@(posedge clk) disable iff (!reset_n)
    int_we |-> (int_waddr != '0))
    else begin
      $error("integer write enabled for register x0");
      fail_count++;
    end

  // Sticky flags only ever gain bits
  flags_sticky: assert property (@(posedge clk) disable iff (!reset_n)
    ((fflags & $past(fflags)) == $past(fflags)))
    else begin
      $error("fflags lost a bit outside reset");
      fail_count++;
    end

endmodule

`default_nettype wire

// ==== hdl/memwb_top.sv ====
// ====================
// MEM, MEM/WB register, WB and both register files
// One cycle from ex_mem to the write ports; no back-pressure
// ====================

`timescale 1ns/1ps
`default_nettype none

`include "rv_consts.svh"

module memwb_top (
  input  logic                   clk,
  input  logic                   reset_n,
  input  rv_pkg::ex_mem_t        ex_mem,
  input  logic [`XLEN-1:0]       dmem_rdata,
  output logic                   int_we,
  output logic [`REG_ADDR_W-1:0] int_waddr,
  output logic [`XLEN-1:0]       int_wdata,
  output logic                   fp_we,
  output logic [`REG_ADDR_W-1:0] fp_waddr,
  output logic [`XLEN-1:0]       fp_wdata,
  output rv_pkg::fp_flags_t      fflags,
  input  logic [`REG_ADDR_W-1:0] int_raddr,
  output logic [`XLEN-1:0]       int_rdata,
  input  logic [`REG_ADDR_W-1:0] fp_raddr,
  output logic [`XLEN-1:0]       fp_rdata
);

  rv_pkg::mem_wb_t mem_wb_next;
  rv_pkg::mem_wb_t mem_wb;

  mem_stage mem_stage_i (
    .ex_mem      (ex_mem),
    .dmem_rdata  (dmem_rdata),
    .mem_wb_next (mem_wb_next)
  );

  memwb_register #(.XLEN(`XLEN)) memwb_register_i (
    .clk        (clk),
    .reset_n    (reset_n),
    .mem_wb_in  (mem_wb_next),
    .mem_wb_out (mem_wb)
  );

  writeback_stage writeback_stage_i (
    .clk       (clk),
    .reset_n   (reset_n),
    .mem_wb    (mem_wb),
    .int_we    (int_we),
    .int_waddr (int_waddr),
    .int_wdata (int_wdata),
    .fp_we     (fp_we),
    .fp_waddr  (fp_waddr),
    .fp_wdata  (fp_wdata),
    .fflags    (fflags)
  );

  // Integer file with x0 hardwired
  regfile #(.ZERO_REG(1'b1)) int_rf_i (
    .clk     (clk),
    .reset_n (reset_n),
    .we      (int_we),
    .waddr   (int_waddr),
    .wdata   (int_wdata),
    .raddr   (int_raddr),
    .rdata   (int_rdata)
  );

  regfile #(.ZERO_REG(1'b0)) fp_rf_i (
    .clk     (clk),
    .reset_n (reset_n),
    .we      (fp_we),
    .waddr   (fp_waddr),
    .wdata   (fp_wdata),
    .raddr   (fp_raddr),
    .rdata   (fp_rdata)
  );

endmodule

`default_nettype wire

// ==== hdl/regfile.sv ====
// ====================
// Register file, one write and one read port
// Reads are combinational and do not see a same-cycle write
// ====================

`timescale 1ns/1ps
`default_nettype none

`include "rv_consts.svh"

module regfile #(
  // 1 hardwires entry 0 to zero on reads
  parameter bit ZERO_REG = 1'b1
) (
  input  logic                   clk,
  input  logic                   reset_n,
  input  logic                   we,
  input  logic [`REG_ADDR_W-1:0] waddr,
  input  logic [`XLEN-1:0]       wdata,
  input  logic [`REG_ADDR_W-1:0] raddr,
  output logic [`XLEN-1:0]       rdata
);

  logic [`XLEN-1:0] regs [`NUM_REGS];
  logic             read_zero;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[waddr] <= wdata;
    end
  end

  // Entry 0 may still hold data in the array, the read masks it
  assign read_zero = ZERO_REG && (raddr == '0);
  assign rdata     = read_zero ? '0 : regs[raddr];

endmodule

`default_nettype wire

// ==== hdl/writeback_stage.sv ====
// ====================
// Write-back. An FP-to-integer result overrides wb_sel
// x0 writes are dropped here; fflags only accumulates until reset
// ====================

`timescale 1ns/1ps
`default_nettype none

`include "rv_consts.svh"

module writeback_stage (
  input  logic                   clk,
  input  logic                   reset_n,
  input  rv_pkg::mem_wb_t        mem_wb,
  output logic                   int_we,
  output logic [`REG_ADDR_W-1:0] int_waddr,
  output logic [`XLEN-1:0]       int_wdata,
  output logic                   fp_we,
  output logic [`REG_ADDR_W-1:0] fp_waddr,
  output logic [`XLEN-1:0]       fp_wdata,
  output rv_pkg::fp_flags_t      fflags
);

  logic [`XLEN-1:0] sel_data;
  logic             fp_item;

  // Integer result source
  always_comb begin
    case (mem_wb.wb_sel)
      rv_pkg::WB_ALU:    sel_data = mem_wb.alu_result;
      rv_pkg::WB_MEM:    sel_data = mem_wb.mem_data;
      rv_pkg::WB_PC4:    sel_data = mem_wb.pc_plus_4;
      rv_pkg::WB_MULDIV: sel_data = mem_wb.mul_div_result;
      rv_pkg::WB_ATOMIC: sel_data = mem_wb.atomic_result;
      rv_pkg::WB_CSR:    sel_data = mem_wb.csr_rdata;
      default:           sel_data = '0;
    endcase
  end

  // FP compares and moves to integer win over wb_sel
  assign int_wdata = mem_wb.int_reg_write_fp ? mem_wb.int_result_fp : sel_data;
  assign int_waddr = mem_wb.rd_addr;
  assign int_we    = mem_wb.valid
                   && (mem_wb.reg_write || mem_wb.int_reg_write_fp)
                   && (mem_wb.rd_addr != '0);

  // The FP file has no hardwired zero, so f0 writes go through
  assign fp_we    = mem_wb.valid && mem_wb.fp_reg_write;
  assign fp_waddr = mem_wb.fp_rd_addr;
  assign fp_wdata = mem_wb.fp_result;

  // Any valid item that writes an FP result to either file can raise flags
  assign fp_item = mem_wb.valid && (mem_wb.fp_reg_write || mem_wb.int_reg_write_fp);

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      fflags <= '0;
    end else if (fp_item) begin
      fflags <= rv_pkg::fp_flags_t'(fflags | mem_wb.fp_flags);
    end
  end

endmodule

`default_nettype wire

// ==== hdl/memwb_register.sv ====
// ====================
// MEM/WB pipeline register. Loads every cycle
// No stall or flush since it feeds the final stage
// ====================

`timescale 1ns/1ps
`default_nettype none

`include "rv_consts.svh"

module memwb_register #(
  parameter int XLEN = `XLEN
) (
  input  logic            clk,
  input  logic            reset_n,
  input  rv_pkg::mem_wb_t mem_wb_in,
  output rv_pkg::mem_wb_t mem_wb_out
);

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      mem_wb_out.alu_result       <= {XLEN{1'b0}};
      mem_wb_out.mem_data         <= {XLEN{1'b0}};
      mem_wb_out.rd_addr          <= '0;
      mem_wb_out.pc_plus_4        <= {XLEN{1'b0}};
      mem_wb_out.reg_write        <= 1'b0;
      mem_wb_out.wb_sel           <= rv_pkg::WB_ALU;
      // Clearing valid alone keeps WB quiet after reset
      mem_wb_out.valid            <= 1'b0;
      mem_wb_out.mul_div_result   <= {XLEN{1'b0}};
      mem_wb_out.atomic_result    <= {XLEN{1'b0}};
      mem_wb_out.csr_rdata        <= {XLEN{1'b0}};
      mem_wb_out.fp_result        <= {XLEN{1'b0}};
      mem_wb_out.int_result_fp    <= {XLEN{1'b0}};
      mem_wb_out.fp_rd_addr       <= '0;
      mem_wb_out.fp_reg_write     <= 1'b0;
      mem_wb_out.int_reg_write_fp <= 1'b0;
      mem_wb_out.fp_flags         <= '0;
    end else begin
      mem_wb_out <= mem_wb_in;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/mem_stage.sv ====
// ====================
// Combinational memory stage. dmem_rdata must be the naturally
// aligned word holding the address; misaligned loads are not detected
// LWU and LD return zero unless XLEN is 64
// ====================

`timescale 1ns/1ps
`default_nettype none

`include "rv_consts.svh"

module mem_stage (
  input  rv_pkg::ex_mem_t  ex_mem,
  input  logic [`XLEN-1:0] dmem_rdata,
  output rv_pkg::mem_wb_t  mem_wb_next
);

  localparam int XLEN = `XLEN;
  // Byte offset bits within one memory word
  localparam int OFF_W = $clog2(XLEN / 8);

  logic [XLEN-1:0] shifted;
  logic [XLEN-1:0] load_data;

  // Move the addressed lane down to bit 0, then extend it
  always_comb begin
    shifted = dmem_rdata >> {ex_mem.alu_result[OFF_W-1:0], 3'b000};
    case (ex_mem.mem_op)
      rv_pkg::MEM_LB: begin
        load_data = XLEN'($signed(shifted[7:0]));
      end
      rv_pkg::MEM_LH: begin
        load_data = XLEN'($signed(shifted[15:0]));
      end
      rv_pkg::MEM_LW: begin
        load_data = XLEN'($signed(shifted[31:0]));
      end
      rv_pkg::MEM_LBU: begin
        load_data = XLEN'(shifted[7:0]);
      end
      rv_pkg::MEM_LHU: begin
        load_data = XLEN'(shifted[15:0]);
      end
      rv_pkg::MEM_LWU: begin
        // RV64 only
        load_data = (XLEN == 64) ? XLEN'(shifted[31:0]) : '0;
      end
      rv_pkg::MEM_LD: begin
        load_data = (XLEN == 64) ? shifted : '0;
      end
      default: begin
        load_data = '0;
      end
    endcase
  end

  // Everything except the load result passes straight through
  always_comb begin
    mem_wb_next.alu_result       = ex_mem.alu_result;
    mem_wb_next.mem_data         = load_data;
    mem_wb_next.rd_addr          = ex_mem.rd_addr;
    mem_wb_next.pc_plus_4        = ex_mem.pc_plus_4;
    mem_wb_next.reg_write        = ex_mem.reg_write;
    mem_wb_next.wb_sel           = ex_mem.wb_sel;
    mem_wb_next.valid            = ex_mem.valid;
    mem_wb_next.mul_div_result   = ex_mem.mul_div_result;
    mem_wb_next.atomic_result    = ex_mem.atomic_result;
    mem_wb_next.csr_rdata        = ex_mem.csr_rdata;
    mem_wb_next.fp_result        = ex_mem.fp_result;
    mem_wb_next.int_result_fp    = ex_mem.int_result_fp;
    mem_wb_next.fp_rd_addr       = ex_mem.fp_rd_addr;
    mem_wb_next.fp_reg_write     = ex_mem.fp_reg_write;
    mem_wb_next.int_reg_write_fp = ex_mem.int_reg_write_fp;
    mem_wb_next.fp_flags         = ex_mem.fp_flags;
  end

endmodule

`default_nettype wire

// ==== hdl/rv_pkg.sv ====
// ====================
// Shared types for the MEM and WB stages
// Field widths follow the macros in rv_consts.svh
// ====================

`default_nettype none

`include "rv_consts.svh"

package rv_pkg;

  // Load opcodes. LWU and LD are only valid on RV64
  typedef enum logic [2:0] {
    MEM_NONE = 3'd0,
    MEM_LB   = 3'd1,
    MEM_LH   = 3'd2,
    MEM_LW   = 3'd3,
    MEM_LBU  = 3'd4,
    MEM_LHU  = 3'd5,
    MEM_LWU  = 3'd6,
    MEM_LD   = 3'd7
  } mem_op_e;

  // Integer write-back source
  typedef enum logic [2:0] {
    WB_ALU    = 3'd0,
    WB_MEM    = 3'd1,
    WB_PC4    = 3'd2,
    WB_MULDIV = 3'd3,
    WB_ATOMIC = 3'd4,
    WB_CSR    = 3'd5
  } wb_sel_e;

  // IEEE exception flags in fflags bit order
  typedef struct packed {
    logic nv;
    logic dz;
    logic of;
    logic uf;
    logic nx;
  } fp_flags_t;

  typedef struct packed {
    logic [`XLEN-1:0]       alu_result;
    mem_op_e                mem_op;
    logic [`REG_ADDR_W-1:0] rd_addr;
    logic [`XLEN-1:0]       pc_plus_4;
    logic                   reg_write;
    wb_sel_e                wb_sel;
    logic                   valid;
    logic [`XLEN-1:0]       mul_div_result;
    logic [`XLEN-1:0]       atomic_result;
    logic [`XLEN-1:0]       csr_rdata;
    logic [`XLEN-1:0]       fp_result;
    logic [`XLEN-1:0]       int_result_fp;
    logic [`REG_ADDR_W-1:0] fp_rd_addr;
    logic                   fp_reg_write;
    logic                   int_reg_write_fp;
    fp_flags_t              fp_flags;
  } ex_mem_t;

  // Same item after the load data has been aligned
  typedef struct packed {
    logic [`XLEN-1:0]       alu_result;
    logic [`XLEN-1:0]       mem_data;
    logic [`REG_ADDR_W-1:0] rd_addr;
    logic [`XLEN-1:0]       pc_plus_4;
    logic                   reg_write;
    wb_sel_e                wb_sel;
    logic                   valid;
    logic [`XLEN-1:0]       mul_div_result;
    logic [`XLEN-1:0]       atomic_result;
    logic [`XLEN-1:0]       csr_rdata;
    logic [`XLEN-1:0]       fp_result;
    logic [`XLEN-1:0]       int_result_fp;
    logic [`REG_ADDR_W-1:0] fp_rd_addr;
    logic                   fp_reg_write;
    logic                   int_reg_write_fp;
    fp_flags_t              fp_flags;
  } mem_wb_t;

endpackage

`default_nettype wire

// ==== hdl/rv_consts.svh ====
// ====================
// Core widths for the back end. XLEN must be 32 or 64
// The doubleword load decodes only when XLEN is 64
// ====================

`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// Data and address width
`define XLEN 32

// Register file addressing
`define REG_ADDR_W 5

`define NUM_REGS 32

`endif
